// ==== logic/soc_cfg_pkg.sv ====
// l2 read path sizing constants

package soc_cfg_pkg;

  // one l2 beat as streamed by the memory
  localparam int unsigned BEAT_W = 64;

  // cluster data port word
  localparam int unsigned CL_WORD_W = 32;

  // word address into l2, one address per beat
  localparam int unsigned L2_AW = 8;

  // burst length field, wide enough for the longest burst
  localparam int unsigned LEN_W = 5;

  // longest burst the cluster DMA issues,
  // also the default depth of the read burst buffer
  localparam int unsigned DMA_MAX_BURST_LEN = 16;

endpackage

// ==== logic/l2_beat_pkg.sv ====
// l2 datapath types

package l2_beat_pkg;

  import soc_cfg_pkg::*;

  // l2 word address
  typedef logic [L2_AW-1:0] l2_addr_t;

  // burst length in beats, zero is not a legal length
  typedef logic [LEN_W-1:0] burst_len_t;

  // one word on the cluster data port
  typedef logic [CL_WORD_W-1:0] cl_word_t;

  // a beat is either one memory word or two cluster words
  // lo goes out first on the cluster side
  typedef union packed {
    logic [BEAT_W-1:0] word;
    struct packed {
      cl_word_t hi;
      cl_word_t lo;
    } halves;
  } l2_beat_u;

endpackage

// ==== logic/l2_mem.sv ====
// l2 word memory with burst streamer
`timescale 1ns/100ps

module l2_mem
  import soc_cfg_pkg::*;
  import l2_beat_pkg::*;
#(
  parameter int unsigned L2_WORDS = 256
) (
  input  logic       clk_i,
  input  logic       rst_n_i,

  // preload port
  input  logic       ext_wr_i,
  input  l2_addr_t   ext_addr_i,
  input  l2_beat_u   ext_wdata_i,

  // burst command from the buffer
  input  logic       rd_start_i,
  input  l2_addr_t   rd_addr_i,
  input  burst_len_t rd_len_i,

  // beat stream to the buffer
  output logic       beat_valid_o,
  output l2_beat_u   beat_data_o
);

  localparam int unsigned IDX_W = $clog2(L2_WORDS);

  logic [BEAT_W-1:0] mem_q [L2_WORDS];

  logic [IDX_W-1:0]  ptr_q;
  logic [LEN_W-1:0]  remain_q;
  logic [IDX_W-1:0]  cur_idx;
  logic [LEN_W-1:0]  cur_left;
  logic              rd_fire;

  // preload writes, upper address bits beyond the array are ignored
  always_ff @(posedge clk_i) begin
    if (ext_wr_i) begin
      mem_q[ext_addr_i[IDX_W-1:0]] <= ext_wdata_i.word;
    end
  end

  // a start command reads its first word right away,
  // so the first beat shows up one cycle after rd_start_i
  always_comb begin
    if (rd_start_i) begin
      cur_idx  = rd_addr_i[IDX_W-1:0];
      cur_left = rd_len_i;
    end else begin
      cur_idx  = ptr_q;
      cur_left = remain_q;
    end
  end

  assign rd_fire = (cur_left != '0);

  // streamer state, index wraps with the array size
  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      ptr_q        <= '0;
      remain_q     <= '0;
      beat_valid_o <= 1'b0;
    end else begin
      beat_valid_o <= rd_fire;
      if (rd_fire) begin
        ptr_q    <= cur_idx + 1'b1;
        remain_q <= cur_left - 1'b1;
      end
    end
  end

  // registered read data
  always_ff @(posedge clk_i) begin
    if (rd_fire) begin
      beat_data_o.word <= mem_q[cur_idx];
    end
  end

endmodule

// ==== logic/read_burst_buffer.sv ====
// read burst buffer
`timescale 1ns/100ps

module read_burst_buffer
  import soc_cfg_pkg::*;
  import l2_beat_pkg::*;
#(
  parameter int unsigned BUF_DEPTH = DMA_MAX_BURST_LEN
) (
  input  logic       clk_i,
  input  logic       rst_n_i,

  // burst requests
  input  logic       burst_req_i,
  input  l2_addr_t   burst_addr_i,
  input  burst_len_t burst_len_i,
  output logic       burst_ack_o,
  output logic       burst_drop_o,

  // memory side
  output logic       rd_start_o,
  output l2_addr_t   rd_addr_o,
  output burst_len_t rd_len_o,
  input  logic       beat_valid_i,
  input  l2_beat_u   beat_data_i,

  // converter side
  input  logic       fifo_pop_i,
  output logic       fifo_empty_o,
  output l2_beat_u   fifo_head_o,
  output logic       buf_busy_o
);

  localparam int unsigned PTR_W = $clog2(BUF_DEPTH);

  logic [BEAT_W-1:0] fifo_q [BUF_DEPTH];
  logic [PTR_W-1:0]  wr_ptr_q;
  logic [PTR_W-1:0]  rd_ptr_q;
  logic [LEN_W-1:0]  count_q;
  // beats still owed by the memory for the admitted burst
  logic [LEN_W-1:0]  due_q;
  logic [LEN_W-1:0]  free_cnt;
  logic              len_ok;
  logic              accept;
  logic              push;
  logic              pop;

  // depth need not be a power of two
  function automatic logic [PTR_W-1:0] ptr_next(input logic [PTR_W-1:0] p);
    if (p == PTR_W'(BUF_DEPTH - 1)) begin
      return '0;
    end
    return p + 1'b1;
  endfunction

  // admission: whole burst must fit and the memory must be idle
  assign free_cnt = LEN_W'(BUF_DEPTH) - count_q;
  assign len_ok   = (burst_len_i != '0) && (burst_len_i <= LEN_W'(BUF_DEPTH));
  assign accept   = burst_req_i && len_ok && (due_q == '0) && (burst_len_i <= free_cnt);

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      burst_ack_o  <= 1'b0;
      burst_drop_o <= 1'b0;
      due_q        <= '0;
    end else begin
      burst_ack_o  <= accept;
      burst_drop_o <= burst_req_i && !accept;
      if (accept) begin
        due_q <= burst_len_i;
      end else if (beat_valid_i) begin
        due_q <= due_q - 1'b1;
      end
    end
  end

  // memory is started in the same cycle as the ack
  assign rd_start_o = burst_ack_o;

  always_ff @(posedge clk_i) begin
    if (accept) begin
      rd_addr_o <= burst_addr_i;
      rd_len_o  <= burst_len_i;
    end
  end

  // beat fifo
  assign push = beat_valid_i;
  assign pop  = fifo_pop_i && (count_q != '0);

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      wr_ptr_q <= '0;
      rd_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      if (push) begin
        wr_ptr_q <= ptr_next(wr_ptr_q);
      end
      if (pop) begin
        rd_ptr_q <= ptr_next(rd_ptr_q);
      end
      case ({push, pop})
        2'b10:   count_q <= count_q + 1'b1;
        2'b01:   count_q <= count_q - 1'b1;
        default: count_q <= count_q;
      endcase
    end
  end

  always_ff @(posedge clk_i) begin
    if (push) begin
      fifo_q[wr_ptr_q] <= beat_data_i.word;
    end
  end

  assign fifo_head_o.word = fifo_q[rd_ptr_q];
  assign fifo_empty_o     = (count_q == '0);
  assign buf_busy_o       = (count_q != '0) || (due_q != '0);

endmodule

// ==== logic/cl_dwc_down.sv ====
// cluster side 64 to 32 down-converter
`timescale 1ns/100ps

module cl_dwc_down
  import l2_beat_pkg::*;
(
  input  logic     clk_i,
  input  logic     rst_n_i,

  // beat fifo
  input  logic     fifo_empty_i,
  input  l2_beat_u fifo_head_i,
  output logic     fifo_pop_o,

  // cluster data port
  input  logic     cl_stall_i,
  output logic     cl_valid_o,
  output cl_word_t cl_data_o,

  output logic     dwc_busy_o
);

  l2_beat_u beat_q;
  // a beat is held
  logic     full_q;
  // high half is on the port
  logic     half_q;

  // take a new beat when nothing is held or the high half leaves now,
  // never while the cluster stalls
  assign fifo_pop_o = !fifo_empty_i && !cl_stall_i && (!full_q || half_q);

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      full_q <= 1'b0;
      half_q <= 1'b0;
    end else if (fifo_pop_o) begin
      full_q <= 1'b1;
      half_q <= 1'b0;
    end else if (full_q && !cl_stall_i) begin
      // low half done, move to high; high half done, release the beat
      half_q <= !half_q;
      if (half_q) begin
        full_q <= 1'b0;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (fifo_pop_o) begin
      beat_q <= fifo_head_i;
    end
  end

  // output holds under stall since no state moves
  assign cl_valid_o = full_q;
  assign cl_data_o  = half_q ? beat_q.halves.hi : beat_q.halves.lo;
  assign dwc_busy_o = full_q;

endmodule

// ==== logic/soc_l2_path.sv ====
// l2 to cluster read path
`timescale 1ns/100ps

module soc_l2_path
  import soc_cfg_pkg::*;
  import l2_beat_pkg::*;
#(
  parameter int unsigned BUF_DEPTH = DMA_MAX_BURST_LEN,
  parameter int unsigned L2_WORDS  = 256
) (
  input  logic       clk_i,
  input  logic       rst_n_i,

  // l2 preload
  input  logic       ext_wr_i,
  input  l2_addr_t   ext_addr_i,
  input  l2_beat_u   ext_wdata_i,

  // burst requests
  input  logic       burst_req_i,
  input  l2_addr_t   burst_addr_i,
  input  burst_len_t burst_len_i,
  output logic       burst_ack_o,
  output logic       burst_drop_o,

  // cluster data port
  input  logic       cl_stall_i,
  output logic       cl_valid_o,
  output cl_word_t   cl_data_o,
  output logic       cl_busy_o
);

  // buffer to memory
  logic       rd_start;
  l2_addr_t   rd_addr;
  burst_len_t rd_len;
  logic       beat_valid;
  l2_beat_u   beat_data;

  // buffer to converter
  logic       fifo_empty;
  l2_beat_u   fifo_head;
  logic       fifo_pop;

  logic       buf_busy;
  logic       dwc_busy;

  l2_mem #(
    .L2_WORDS (L2_WORDS)
  ) i_l2_mem (
    .clk_i,
    .rst_n_i,
    .ext_wr_i,
    .ext_addr_i,
    .ext_wdata_i,
    .rd_start_i   (rd_start),
    .rd_addr_i    (rd_addr),
    .rd_len_i     (rd_len),
    .beat_valid_o (beat_valid),
    .beat_data_o  (beat_data)
  );

  read_burst_buffer #(
    .BUF_DEPTH (BUF_DEPTH)
  ) i_r_buf (
    .clk_i,
    .rst_n_i,
    .burst_req_i,
    .burst_addr_i,
    .burst_len_i,
    .burst_ack_o,
    .burst_drop_o,
    .rd_start_o   (rd_start),
    .rd_addr_o    (rd_addr),
    .rd_len_o     (rd_len),
    .beat_valid_i (beat_valid),
    .beat_data_i  (beat_data),
    .fifo_pop_i   (fifo_pop),
    .fifo_empty_o (fifo_empty),
    .fifo_head_o  (fifo_head),
    .buf_busy_o   (buf_busy)
  );

  cl_dwc_down i_dwc (
    .clk_i,
    .rst_n_i,
    .fifo_empty_i (fifo_empty),
    .fifo_head_i  (fifo_head),
    .fifo_pop_o   (fifo_pop),
    .cl_stall_i,
    .cl_valid_o,
    .cl_data_o,
    .dwc_busy_o   (dwc_busy)
  );

  assign cl_busy_o = buf_busy || dwc_busy;

endmodule

// ==== test/soc_l2_path_asserts.sv ====
// burst buffer assertions
`timescale 1ns/100ps

module soc_l2_path_asserts
  import soc_cfg_pkg::*;
#(
  parameter int unsigned BUF_DEPTH = DMA_MAX_BURST_LEN
) (
  input logic             clk_i,
  input logic             rst_n_i,
  input logic             ack_i,
  input logic             drop_i,
  input logic             beat_valid_i,
  input logic [LEN_W-1:0] count_i,
  input logic [LEN_W-1:0] due_i
);

  // one answer per request
  ack_drop_excl: assert property (
    @(posedge clk_i) disable iff (!rst_n_i) !(ack_i && drop_i)
  ) else $error("burst ack and drop high together");

  count_in_range: assert property (
    @(posedge clk_i) disable iff (!rst_n_i) count_i <= LEN_W'(BUF_DEPTH)
  ) else $error("burst buffer holds more beats than its depth");

  // memory only streams beats that were reserved
  beat_was_due: assert property (
    @(posedge clk_i) disable iff (!rst_n_i) beat_valid_i |-> (due_i != '0)
  ) else $error("beat arrived while no beats were due");

endmodule

bind read_burst_buffer soc_l2_path_asserts #(
  .BUF_DEPTH (BUF_DEPTH)
) i_asserts (
  .clk_i        (clk_i),
  .rst_n_i      (rst_n_i),
  .ack_i        (burst_ack_o),
  .drop_i       (burst_drop_o),
  .beat_valid_i (beat_valid_i),
  .count_i      (count_q),
  .due_i        (due_q)
);

// ==== test/soc_l2_path_tb.sv ====
// l2 read path testbench
`timescale 1ns/100ps

module soc_l2_path_tb
  import soc_cfg_pkg::*;
  import l2_beat_pkg::*;
();

  localparam int BUF_DEPTH   = 8;
  localparam int L2_WORDS    = 256;
  localparam int N_REQ       = 47;
  // each request may need a full burst drain plus the pipeline latency
  localparam int CYCLE_LIMIT = N_REQ * (BUF_DEPTH * 2 + 8) + L2_WORDS + 400;

  logic       clk_i = 1'b0;
  logic       rst_n_i;
  logic       ext_wr_i;
  l2_addr_t   ext_addr_i;
  l2_beat_u   ext_wdata_i;
  logic       burst_req_i;
  l2_addr_t   burst_addr_i;
  burst_len_t burst_len_i;
  logic       burst_ack_o;
  logic       burst_drop_o;
  logic       cl_stall_i = 1'b0;
  logic       cl_valid_o;
  cl_word_t   cl_data_o;
  logic       cl_busy_o;

  logic [31:0] lfsr_q       = 32'd83534;
  logic [31:0] stall_lfsr_q = 32'd83534;
  logic        stall_bit;
  logic        stall_en     = 1'b0;
  int          cycles       = 0;
  int          errors       = 0;
  int          checks       = 0;
  string       test_name    = "reset";

  // reference model
  l2_beat_u    model_mem [L2_WORDS];
  cl_word_t    exp_words [$];
  l2_beat_u    exp_beats [$];

  // monitor state
  logic        pend_q     = 1'b0;
  l2_addr_t    pend_addr;
  burst_len_t  pend_len;
  logic        pend_idle;
  logic        prev_valid = 1'b0;
  logic        prev_stall = 1'b0;
  cl_word_t    prev_data;
  logic        got_half   = 1'b0;
  l2_beat_u    got_beat;
  l2_beat_u    exp_b;
  cl_word_t    exp_w;

  soc_l2_path #(
    .BUF_DEPTH (BUF_DEPTH),
    .L2_WORDS  (L2_WORDS)
  ) dut0 (.*);

  always #4 clk_i = ~clk_i;

  always @(posedge clk_i) begin
    cycles <= cycles + 1;
    if (cycles >= CYCLE_LIMIT) begin
      $display("timeout: run still going after %0d cycles", cycles);
      $display("ERRORS FOUND");
      $finish;
    end
  end

  // taps 32 22 2 1
  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
  endfunction

  task automatic draw(input int n, output logic [63:0] v);
    v = '0;
    for (int i = 0; i < n; i++) begin
      lfsr_q = lfsr_next(lfsr_q);
      v = {v[62:0], lfsr_q[0]};
    end
  endtask

  // stall roughly one cycle in four
  always @(posedge clk_i) begin
    stall_lfsr_q = lfsr_next(stall_lfsr_q);
    stall_bit    = stall_lfsr_q[0];
    stall_lfsr_q = lfsr_next(stall_lfsr_q);
    cl_stall_i <= stall_en && stall_bit && stall_lfsr_q[0];
  end

  task automatic check_word(input string what, input cl_word_t exp, input cl_word_t act);
    checks++;
    if (act !== exp) begin
      errors++;
      $display("Error %s %s: expected %h, actual %h", test_name, what, exp, act);
    end
  endtask

  task automatic check_beat(input string what, input l2_beat_u exp, input l2_beat_u act);
    checks++;
    if (act.word !== exp.word) begin
      errors++;
      $display("Error %s %s: expected %h, actual %h", test_name, what, exp.word, act.word);
    end
  endtask

  task automatic check_flag(input string what, input logic exp, input logic act);
    checks++;
    if (act !== exp) begin
      errors++;
      $display("Error %s %s: expected %b, actual %b", test_name, what, exp, act);
    end
  endtask

  task automatic report_fail(input string text);
    errors++;
    $display("%s: %s", test_name, text);
  endtask

  // expected words of an acknowledged burst
  // the address wraps at the top of l2
  function automatic void push_burst(input l2_addr_t a, input burst_len_t len);
    l2_beat_u b;
    for (int i = 0; i < int'(len); i++) begin
      b = model_mem[(int'(a) + i) % L2_WORDS];
      exp_beats.push_back(b);
      exp_words.push_back(b.halves.lo);
      exp_words.push_back(b.halves.hi);
    end
  endfunction

  // outputs are sampled mid cycle
  always @(negedge clk_i) begin
    if (rst_n_i === 1'b1) begin
      if (pend_q) begin
        if (burst_ack_o && burst_drop_o) begin
          report_fail("one request got both ack and drop");
        end else if (!burst_ack_o && !burst_drop_o) begin
          report_fail("request got neither ack nor drop one cycle later");
        end
        if (pend_len == '0 || int'(pend_len) > BUF_DEPTH) begin
          check_flag("drop of illegal length", 1'b1, burst_drop_o);
        end else if (pend_idle) begin
          check_flag("ack while idle", 1'b1, burst_ack_o);
        end
        if (burst_ack_o) begin
          push_burst(pend_addr, pend_len);
        end
      end else if (burst_ack_o || burst_drop_o) begin
        report_fail("ack or drop without a request");
      end
      pend_q    = burst_req_i;
      pend_addr = burst_addr_i;
      pend_len  = burst_len_i;
      pend_idle = !cl_busy_o;

      // words still owed to the cluster keep the path busy
      check_flag("busy while words are owed", exp_words.size() != 0, cl_busy_o);

      if (prev_valid && prev_stall) begin
        check_flag("valid held under stall", 1'b1, cl_valid_o);
        check_word("data held under stall", prev_data, cl_data_o);
      end
      // a word leaves at the next edge
      if (cl_valid_o && !cl_stall_i) begin
        if (exp_words.size() == 0) begin
          report_fail("cluster word came out with none expected");
        end else begin
          exp_w = exp_words.pop_front();
          check_word("cluster word", exp_w, cl_data_o);
          if (!got_half) begin
            got_beat.halves.lo = cl_data_o;
          end else begin
            got_beat.halves.hi = cl_data_o;
            exp_b = exp_beats.pop_front();
            check_beat("rebuilt beat", exp_b, got_beat);
          end
          got_half = !got_half;
        end
      end
      prev_valid = cl_valid_o;
      prev_stall = cl_stall_i;
      prev_data  = cl_data_o;
    end
  end

  task automatic send_req(input l2_addr_t a, input burst_len_t len);
    burst_req_i  <= 1'b1;
    burst_addr_i <= a;
    burst_len_i  <= len;
    @(posedge clk_i);
    burst_req_i  <= 1'b0;
  endtask

  task automatic wait_idle();
    do begin
      @(negedge clk_i);
    end while (cl_busy_o);
    @(posedge clk_i);
  endtask

  task automatic finish_test(input int errs_before);
    if (exp_words.size() != 0) begin
      report_fail($sformatf("%0d expected words never came out", exp_words.size()));
      exp_words.delete();
      exp_beats.delete();
    end
    $display("test %s done, %0d errors", test_name, errors - errs_before);
  endtask

  initial begin
    logic [63:0] r;
    int          e0;
    rst_n_i      = 1'b0;
    ext_wr_i     = 1'b0;
    ext_addr_i   = '0;
    ext_wdata_i  = '0;
    burst_req_i  = 1'b0;
    burst_addr_i = '0;
    burst_len_i  = '0;
    repeat (4) @(posedge clk_i);
    rst_n_i <= 1'b1;
    @(posedge clk_i);

    test_name = "preload_burst";
    e0 = errors;
    for (int i = 0; i < L2_WORDS; i++) begin
      draw(64, r);
      model_mem[i] = r;
      ext_wr_i    <= 1'b1;
      ext_addr_i  <= l2_addr_t'(i);
      ext_wdata_i <= r;
      @(posedge clk_i);
    end
    ext_wr_i <= 1'b0;
    // crosses the top address
    send_req(8'd252, 5'd8);
    wait_idle();
    finish_test(e0);

    test_name = "response_pulse";
    e0 = errors;
    send_req(8'd3, 5'd0);
    send_req(8'd40, burst_len_t'(BUF_DEPTH + 1));
    send_req(8'd77, 5'd16);
    send_req(8'd200, 5'd31);
    send_req(8'd250, burst_len_t'(BUF_DEPTH));
    wait_idle();
    send_req(8'd9, 5'd1);
    wait_idle();
    finish_test(e0);

    test_name = "idle_admission";
    e0 = errors;
    for (int k = 0; k < 8; k++) begin
      draw(11, r);
      send_req(r[10:3], burst_len_t'(int'(r[2:0]) + 1));
      wait_idle();
    end
    finish_test(e0);

    test_name = "random_stall";
    e0 = errors;
    stall_en <= 1'b1;
    for (int k = 0; k < 8; k++) begin
      draw(11, r);
      send_req(r[10:3], burst_len_t'(int'(r[2:0]) + 1));
      wait_idle();
    end
    finish_test(e0);

    test_name = "back_to_back";
    e0 = errors;
    for (int k = 0; k < 24; k++) begin
      draw(14, r);
      send_req(r[13:6], burst_len_t'(r[5:2]));
      repeat (int'(r[1:0])) @(posedge clk_i);
    end
    wait_idle();
    stall_en <= 1'b0;
    finish_test(e0);

    $display("all tests done: %0d checks, %0d errors", checks, errors);
    if (errors == 0) begin
      $display("NO ERRORS");
    end else begin
      $display("ERRORS FOUND");
    end
    $finish;
  end

endmodule

// ==== soc_l2_path.f ====
logic/soc_cfg_pkg.sv
logic/l2_beat_pkg.sv
logic/l2_mem.sv
logic/read_burst_buffer.sv
logic/cl_dwc_down.sv
logic/soc_l2_path.sv
test/soc_l2_path_asserts.sv
test/soc_l2_path_tb.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# build and run the l2 read path testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log

if ! verilator --binary --timing --assert -j 0 \
    --top-module soc_l2_path_tb \
    -f soc_l2_path.f \
    -o sim_soc_l2_path; then
  echo "build failed"
  exit 1
fi

./obj_dir/sim_soc_l2_path > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
  echo "simulation exited with status $status"
  exit 1
fi

if grep -qx "NO ERRORS" "$LOG"; then
  echo "PASS"
  exit 0
else
  echo "FAIL"
  exit 1
fi
